//--- verilog/nx_settings.svh
// Mesh node build settings for field widths and buffer depths
`ifndef NX_SETTINGS_SVH
`define NX_SETTINGS_SVH

// Width of one row or column coordinate
`define NX_ADDR_W 4

// Message payload width
`define NX_PAYLOAD_W 24

// Router FIFO depth
`define NX_ROUTE_DEPTH 2

// Depth of each egress FIFO in the distributor
`define NX_EGRESS_DEPTH 2

`endif

//--- verilog/nx_pkg.sv
// Shared direction, address and message types for the mesh node
`include "nx_settings.svh"

package nx_pkg;

    // Mesh directions, clockwise from north
    typedef enum logic [1:0] {
        DIRECTION_NORTH = 2'd0,
        DIRECTION_EAST  = 2'd1,
        DIRECTION_SOUTH = 2'd2,
        DIRECTION_WEST  = 2'd3
    } direction_t;

    // Position of a node in the mesh
    typedef struct packed {
        logic [`NX_ADDR_W-1:0] row;
        logic [`NX_ADDR_W-1:0] col;
    } node_id_t;

    // Message as carried on every stream
    typedef struct packed {
        node_id_t                 target;
        logic [`NX_PAYLOAD_W-1:0] payload;
    } node_message_t;

    // Message with its routing decision attached
    typedef struct packed {
        node_message_t message;
        direction_t    dir;
        logic          is_local;
    } routed_message_t;

endpackage : nx_pkg

//--- verilog/nx_fifo.sv
// Small synchronous FIFO holding any packed payload type
`timescale 1ns/100ps

module nx_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 2
) (
    input  logic     clk_i,
    input  logic     arst_n_i,
    // Write side
    input  payload_t wr_data_i,
    input  logic     wr_push_i,
    // Read side
    output payload_t rd_data_o,
    input  logic     rd_pop_i,
    // Status
    output logic     empty_o,
    output logic     full_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t             mem [DEPTH];
    logic     [PTR_W-1:0] wr_ptr_q;
    logic     [PTR_W-1:0] rd_ptr_q;
    logic     [CNT_W-1:0] count_q;
    logic                 do_push;
    logic                 do_pop;

    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == CNT_W'(DEPTH));

    // Requests that cannot be honoured are dropped
    assign do_push = wr_push_i && !full_o;
    assign do_pop  = rd_pop_i && !empty_o;

    assign rd_data_o = mem[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr_q] <= wr_data_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // Simultaneous push and pop leaves the level unchanged
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule : nx_fifo

//--- verilog/nx_stream_combiner.sv
// Round-robin combiner merging the four inbound streams into one
`timescale 1ns/100ps

module nx_stream_combiner
    import nx_pkg::*;
(
    input  logic                clk_i,
    input  logic                arst_n_i,
    // Inbound streams, indexed by direction
    input  node_message_t [3:0] in_data_i,
    input  logic          [3:0] in_valid_i,
    output logic          [3:0] in_ready_o,
    // Merged stream
    output node_message_t       out_data_o,
    output logic                out_valid_o,
    input  logic                out_ready_i
);

    direction_t last_q;
    direction_t grant;
    logic [1:0] cand;
    logic       found;

    // Search begins one past the previous winner
    always_comb begin
        grant = last_q;
        found = 1'b0;
        cand  = '0;
        for (int i = 1; i <= 4; i++) begin
            cand = 2'(int'(last_q) + i);
            if (!found && in_valid_i[cand]) begin
                grant = direction_t'(cand);
                found = 1'b1;
            end
        end
    end

    assign out_valid_o = found;
    assign out_data_o  = in_data_i[grant];

    // Only the winning input sees ready
    always_comb begin
        in_ready_o        = '0;
        in_ready_o[grant] = out_ready_i && found;
    end

    // Pointer moves only when a message has actually left
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            last_q <= DIRECTION_WEST;
        end else if (out_valid_o && out_ready_i) begin
            last_q <= grant;
        end
    end

endmodule : nx_stream_combiner

//--- verilog/nx_node_router.sv
// Node router picking a direction per message, column first, then row
`timescale 1ns/100ps
`include "nx_settings.svh"

module nx_node_router
    import nx_pkg::*;
(
    input  logic          clk_i,
    input  logic          arst_n_i,
    // Own position in the mesh
    input  node_id_t      node_id_i,
    // Inbound merged stream
    input  node_message_t in_data_i,
    input  logic          in_valid_i,
    output logic          in_ready_o,
    // Onward traffic to the distributor
    output node_message_t dist_data_o,
    output direction_t    dist_dir_o,
    output logic          dist_valid_o,
    input  logic          dist_ready_i,
    // Traffic addressed to this node
    output node_message_t local_data_o,
    output logic          local_valid_o,
    input  logic          local_ready_i,
    output logic          empty_o
);

    routed_message_t entry;
    routed_message_t head;
    logic            full;
    logic            pop;

    // Column first, then row
    always_comb begin
        entry.message  = in_data_i;
        entry.dir      = DIRECTION_NORTH;
        entry.is_local = 1'b0;
        if (in_data_i.target.col > node_id_i.col) begin
            entry.dir = DIRECTION_EAST;
        end else if (in_data_i.target.col < node_id_i.col) begin
            entry.dir = DIRECTION_WEST;
        end else if (in_data_i.target.row > node_id_i.row) begin
            entry.dir = DIRECTION_SOUTH;
        end else if (in_data_i.target.row < node_id_i.row) begin
            entry.dir = DIRECTION_NORTH;
        end else begin
            entry.is_local = 1'b1;
        end
    end

    assign in_ready_o = !full;

    nx_fifo #(
        .payload_t (routed_message_t),
        .DEPTH     (`NX_ROUTE_DEPTH)
    ) u_route_fifo (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .wr_data_i (entry),
        .wr_push_i (in_valid_i && !full),
        .rd_data_o (head),
        .rd_pop_i  (pop),
        .empty_o   (empty_o),
        .full_o    (full)
    );

    // Head goes either local or onward, never both
    assign local_data_o  = head.message;
    assign local_valid_o = !empty_o && head.is_local;
    assign dist_data_o   = head.message;
    assign dist_dir_o    = head.dir;
    assign dist_valid_o  = !empty_o && !head.is_local;

    assign pop = (local_valid_o && local_ready_i) || (dist_valid_o && dist_ready_i);

endmodule : nx_node_router

//--- verilog/nx_stream_distributor.sv
// Stream distributor with per-direction egress FIFOs and clockwise aliasing
`timescale 1ns/100ps
`include "nx_settings.svh"

module nx_stream_distributor
    import nx_pkg::*;
(
    input  logic                clk_i,
    input  logic                arst_n_i,
    // Routed message from the router
    input  node_message_t       dist_data_i,
    input  direction_t          dist_dir_i,
    input  logic                dist_valid_i,
    output logic                dist_ready_o,
    // Egress streams, indexed by direction
    output node_message_t [3:0] egress_data_o,
    output logic          [3:0] egress_valid_o,
    input  logic          [3:0] egress_ready_i,
    input  logic          [3:0] egress_present_i,
    // All egress FIFOs drained
    output logic                empty_o
);

    direction_t target_dir;
    logic [3:0] egress_full;
    logic [3:0] egress_empty;
    logic [3:0] egress_push;
    logic [3:0] egress_pop;

    // An absent neighbour hands its traffic to the next one clockwise.
    // There is no second step, so a missing alias still gets the message.
    always_comb begin
        if (egress_present_i[dist_dir_i]) begin
            target_dir = dist_dir_i;
        end else begin
            case (dist_dir_i)
                DIRECTION_NORTH: target_dir = DIRECTION_EAST;
                DIRECTION_EAST:  target_dir = DIRECTION_SOUTH;
                DIRECTION_SOUTH: target_dir = DIRECTION_WEST;
                default:         target_dir = DIRECTION_NORTH;
            endcase
        end
    end

    // Ready follows only the FIFO that would take the message
    assign dist_ready_o = !egress_full[target_dir];

    always_comb begin
        egress_push             = '0;
        egress_push[target_dir] = dist_valid_i && dist_ready_o;
    end

    for (genvar i = 0; i < 4; i++) begin : g_egress
        assign egress_pop[i]     = !egress_empty[i] && egress_ready_i[i];
        assign egress_valid_o[i] = !egress_empty[i];

        nx_fifo #(
            .payload_t (node_message_t),
            .DEPTH     (`NX_EGRESS_DEPTH)
        ) u_egress_fifo (
            .clk_i     (clk_i),
            .arst_n_i  (arst_n_i),
            .wr_data_i (dist_data_i),
            .wr_push_i (egress_push[i]),
            .rd_data_o (egress_data_o[i]),
            .rd_pop_i  (egress_pop[i]),
            .empty_o   (egress_empty[i]),
            .full_o    (egress_full[i])
        );
    end

    assign empty_o = &egress_empty;

endmodule : nx_stream_distributor

//--- verilog/nx_node.sv
// Mesh node top combining inbound streams, routing and egress distribution
`timescale 1ns/100ps

module nx_node
    import nx_pkg::*;
(
    input  logic                clk_i,
    input  logic                arst_n_i,
    // Own position in the mesh
    input  node_id_t            node_id_i,
    // Inbound streams from north, east, south and west
    input  node_message_t [3:0] in_data_i,
    input  logic          [3:0] in_valid_i,
    output logic          [3:0] in_ready_o,
    // Egress streams towards the neighbours
    output node_message_t [3:0] egress_data_o,
    output logic          [3:0] egress_valid_o,
    input  logic          [3:0] egress_ready_i,
    input  logic          [3:0] egress_present_i,
    // Messages for this node
    output node_message_t       local_data_o,
    output logic                local_valid_o,
    input  logic                local_ready_i,
    output logic                idle_o
);

    // Combiner to router
    node_message_t comb_data;
    logic          comb_valid;
    logic          comb_ready;

    // Router to distributor
    node_message_t dist_data;
    direction_t    dist_dir;
    logic          dist_valid;
    logic          dist_ready;

    logic          router_empty;
    logic          dist_empty;

    nx_stream_combiner u_combiner (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .in_data_i   (in_data_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .out_data_o  (comb_data),
        .out_valid_o (comb_valid),
        .out_ready_i (comb_ready)
    );

    nx_node_router u_router (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .node_id_i     (node_id_i),
        .in_data_i     (comb_data),
        .in_valid_i    (comb_valid),
        .in_ready_o    (comb_ready),
        .dist_data_o   (dist_data),
        .dist_dir_o    (dist_dir),
        .dist_valid_o  (dist_valid),
        .dist_ready_i  (dist_ready),
        .local_data_o  (local_data_o),
        .local_valid_o (local_valid_o),
        .local_ready_i (local_ready_i),
        .empty_o       (router_empty)
    );

    nx_stream_distributor u_distributor (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .dist_data_i      (dist_data),
        .dist_dir_i       (dist_dir),
        .dist_valid_i     (dist_valid),
        .dist_ready_o     (dist_ready),
        .egress_data_o    (egress_data_o),
        .egress_valid_o   (egress_valid_o),
        .egress_ready_i   (egress_ready_i),
        .egress_present_i (egress_present_i),
        .empty_o          (dist_empty)
    );

    // Nothing buffered and nothing waiting at the inputs
    assign idle_o = router_empty && dist_empty && !(|in_valid_i);

endmodule : nx_node

//--- test/nx_node_tb.sv
// Testbench for the mesh node, driven from a data file of routing cases
`timescale 1ns/100ps
`include "nx_settings.svh"

module nx_node_tb
    import nx_pkg::*;
;

    localparam int    CLK_PERIOD      = 4;
    localparam int    CYCLES_PER_MSG  = 200;
    localparam string DATA_FILE       = "test/nx_node_testdata.txt";

    // One line of the data file
    typedef struct packed {
        logic          is_mask;
        logic [3:0]    mask;
        logic [1:0]    port;
        logic [2:0]    exp_port;
        node_message_t msg;
    } step_t;

    logic                clk_i;
    logic                arst_n_i;
    node_id_t            node_id_i;
    node_message_t [3:0] in_data_i;
    logic          [3:0] in_valid_i;
    logic          [3:0] in_ready_o;
    node_message_t [3:0] egress_data_o;
    logic          [3:0] egress_valid_o;
    logic          [3:0] egress_ready_i;
    logic          [3:0] egress_present_i;
    node_message_t       local_data_o;
    logic                local_valid_o;
    logic                local_ready_i;
    logic                idle_o;

    step_t         steps[$];
    node_message_t send_q[4][$];
    // Expected messages, indexed by inbound port * 5 + outbound port
    node_message_t exp_q[20][$];
    int            num_msgs = 0;
    logic          loaded   = 1'b0;
    integer        seed     = 32'hb132;

    nx_node u_nx_node (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .node_id_i        (node_id_i),
        .in_data_i        (in_data_i),
        .in_valid_i       (in_valid_i),
        .in_ready_o       (in_ready_o),
        .egress_data_o    (egress_data_o),
        .egress_valid_o   (egress_valid_o),
        .egress_ready_i   (egress_ready_i),
        .egress_present_i (egress_present_i),
        .local_data_o     (local_data_o),
        .local_valid_o    (local_valid_o),
        .local_ready_i    (local_ready_i),
        .idle_o           (idle_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    task automatic abort_run();
        $display("Something failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic report_error(input string why);
        $display("ERROR: %s", why);
        abort_run();
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, expected);
        abort_run();
    endtask

    function automatic int pending_count();
        int total;
        total = 0;
        for (int i = 0; i < 20; i++) begin
            total += exp_q[i].size();
        end
        return total;
    endfunction

    task automatic load_steps();
        int          fd;
        int          code;
        string       tok;
        string       rest;
        int          port;
        int          row;
        int          col;
        int          exp_port;
        logic [31:0] value;
        step_t       step;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            report_error("Cannot open the test data file");
        end else begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                step = '0;
                if (tok.substr(0, 0) == "#") begin
                    code = $fgets(rest, fd);
                end else if (tok == "P") begin
                    code = $fscanf(fd, "%h", value);
                    step.is_mask = 1'b1;
                    step.mask    = value[3:0];
                    steps.push_back(step);
                end else if (tok == "M") begin
                    code = $fscanf(fd, "%d %d %d %h %d", port, row, col, value, exp_port);
                    // Top payload nibble names the inbound port
                    if (code != 5 || port > 3 || exp_port > 4 || value[31:24] != 0 ||
                        value[23:20] != port) begin
                        report_error("Malformed message line in the test data file");
                    end else begin
                        step.port              = port[1:0];
                        step.exp_port          = exp_port[2:0];
                        step.msg.target.row    = row[`NX_ADDR_W-1:0];
                        step.msg.target.col    = col[`NX_ADDR_W-1:0];
                        step.msg.payload       = value[`NX_PAYLOAD_W-1:0];
                        steps.push_back(step);
                        num_msgs++;
                    end
                end else begin
                    report_error("Unknown record in the test data file");
                end
            end
            $fclose(fd);
        end
    endtask

    // Holds one inbound stream busy until its queue is empty
    task automatic send_port(input int port);
        while (send_q[port].size() != 0) begin
            @(negedge clk_i);
            in_data_i[port]  = send_q[port][0];
            in_valid_i[port] = 1'b1;
            @(posedge clk_i);
            while (!in_ready_o[port]) begin
                @(posedge clk_i);
            end
            void'(send_q[port].pop_front());
        end
        @(negedge clk_i);
        in_valid_i[port] = 1'b0;
    endtask

    // All four inputs burst at once, then everything drains
    task automatic run_group();
        fork
            send_port(0);
            send_port(1);
            send_port(2);
            send_port(3);
        join
        while (pending_count() != 0) begin
            @(negedge clk_i);
        end
    endtask

    task automatic check_out(input int out_port, input node_message_t got);
        int            src;
        string         name;
        node_message_t expected;
        src  = int'(got.payload[`NX_PAYLOAD_W-1 -: 4]);
        name = (out_port == 4) ? "local_data_o" : $sformatf("egress_data_o[%0d]", out_port);
        if (src > 3) begin
            report_error($sformatf("Message with an unknown source tag left on %s", name));
        end else if (exp_q[src * 5 + out_port].size() == 0) begin
            report_error($sformatf("Unexpected message 0x%0h left on %s", got, name));
        end else begin
            expected = exp_q[src * 5 + out_port].pop_front();
            assert (got == expected) else report_mismatch(name, got, expected);
        end
    endtask

    // Output monitor
    initial begin
        forever begin
            @(posedge clk_i);
            if (arst_n_i) begin
                // Buffered or waiting traffic means the node is busy
                if ((|egress_valid_o) || local_valid_o || (|in_valid_i)) begin
                    assert (!idle_o) else report_mismatch("idle_o", idle_o, 0);
                end
                for (int o = 0; o < 4; o++) begin
                    if (egress_valid_o[o] && egress_ready_i[o]) begin
                        check_out(o, egress_data_o[o]);
                    end
                end
                if (local_valid_o && local_ready_i) begin
                    check_out(4, local_data_o);
                end
            end
        end
    end

    // Random output ready with occasional long stalls
    initial begin
        logic        stall;
        logic [31:0] rnd;
        int          cycle;
        stall = 1'b0;
        cycle = 0;
        forever begin
            @(negedge clk_i);
            if (arst_n_i) begin
                if (cycle % 32 == 0) begin
                    stall = (($random(seed) & 3) == 0);
                end
                cycle++;
                rnd = $random(seed);
                for (int i = 0; i < 4; i++) begin
                    egress_ready_i[i] = stall ? (rnd[4*i +: 4] == 0) : (rnd[4*i +: 2] != 0);
                end
                local_ready_i = stall ? (rnd[16 +: 4] == 0) : (rnd[16 +: 2] != 0);
            end
        end
    end

    initial begin
        wait (loaded);
        repeat (CYCLES_PER_MSG * num_msgs) @(posedge clk_i);
        report_error("Timeout, the messages did not all arrive in time");
    end

    initial begin
        arst_n_i         = 1'b0;
        node_id_i.row    = 2;
        node_id_i.col    = 2;
        in_data_i        = '0;
        in_valid_i       = '0;
        egress_ready_i   = '0;
        egress_present_i = 4'hf;
        local_ready_i    = 1'b0;
        load_steps();
        loaded = 1'b1;
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        arst_n_i = 1'b1;

        // Quiet after reset
        @(negedge clk_i);
        assert (egress_valid_o == 4'h0) else report_mismatch("egress_valid_o", egress_valid_o, 0);
        assert (!local_valid_o) else report_mismatch("local_valid_o", local_valid_o, 0);
        assert (idle_o) else report_mismatch("idle_o", idle_o, 1);

        foreach (steps[i]) begin
            if (steps[i].is_mask) begin
                run_group();
                @(negedge clk_i);
                egress_present_i = steps[i].mask;
            end else begin
                send_q[steps[i].port].push_back(steps[i].msg);
                exp_q[steps[i].port * 5 + steps[i].exp_port].push_back(steps[i].msg);
            end
        end
        run_group();

        repeat (2) @(negedge clk_i);
        assert (idle_o) else report_mismatch("idle_o", idle_o, 1);
        $display("Everything OK");
        $finish;
    end

endmodule : nx_node_tb

//--- test/nx_node_testdata.txt
# P <present mask hex, bit 0..3 = north east south west>
# M <inbound port> <row> <col> <payload hex, top nibble = inbound port> <out port, 4 = local>
P f
M 0 2 3 000001 1
M 1 2 1 100002 3
M 2 3 2 200003 2
M 3 1 2 300004 0
M 0 2 2 000005 4
M 1 0 0 100006 3
M 2 2 2 200007 4
M 3 5 7 300008 1
P e
M 0 0 2 00000a 1
M 1 2 0 10000b 3
M 2 4 2 20000c 2
M 3 2 4 30000d 1
P b
M 0 3 2 00000e 3
M 1 1 2 10000f 0
M 2 2 5 200010 1
P f
M 0 2 3 000011 1
M 0 2 3 000012 1
M 0 2 2 000013 4
M 1 2 3 100014 1
M 1 2 3 100015 1
M 2 2 3 200016 1
M 2 2 2 200017 4
M 3 2 3 300018 1
M 3 2 3 300019 1
M 3 0 1 30001a 3

//--- sources.f
+incdir+verilog
verilog/nx_pkg.sv
verilog/nx_fifo.sv
verilog/nx_stream_combiner.sv
verilog/nx_node_router.sv
verilog/nx_stream_distributor.sv
verilog/nx_node.sv
test/nx_node_tb.sv

//--- Bender.yml
package:
  name: nx_node

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/nx_pkg.sv
      - verilog/nx_fifo.sv
      - verilog/nx_stream_combiner.sv
      - verilog/nx_node_router.sv
      - verilog/nx_stream_distributor.sv
      - verilog/nx_node.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/nx_node_tb.sv
